/* verilog/i3c_target_pkg.sv */
// Bus event, request and response structs, CCC codes, owner enum and address constants
package i3c_target_pkg;

  // Decoded bus events, one set per clock
  typedef struct packed {
    logic start_det;
    logic stop_det;
    logic scl_posedge;
    logic scl_negedge;
    logic sda_value;
  } bus_state_t;

  typedef struct packed {
    logic rx_req_byte;
    logic rx_req_bit;
    logic tx_req_bit;
    logic tx_value;
  } bus_req_t;

  // Sampled bit of a bit request lands in rx_data[0]
  typedef struct packed {
    logic       rx_done;
    logic [7:0] rx_data;
    logic       tx_done;
  } bus_rsp_t;

  typedef struct packed {
    logic [6:0] sta_addr;
    logic       sta_addr_valid;
    logic [6:0] dyn_addr;
    logic       dyn_addr_valid;
  } target_cfg_t;

  typedef struct packed {
    logic enec_ibi;
    logic enec_hj;
    logic disec_ibi;
    logic disec_hj;
    logic set_mwl;
    logic rst_action_valid;
  } ccc_events_t;

  typedef enum logic {
    sel_fsm,
    sel_ccc
  } xfer_sel_e;

  localparam logic [6:0] BroadcastAddr = 7'h7E;

  // Broadcast CCC codes
  localparam logic [7:0] CccEnec   = 8'h00;
  localparam logic [7:0] CccDisec  = 8'h01;
  localparam logic [7:0] CccSetmwl = 8'h09;
  localparam logic [7:0] CccRstact = 8'h2A;

  // RSTACT defining bytes
  localparam logic [7:0] RstactPeriph   = 8'h01;
  localparam logic [7:0] RstactEscalate = 8'h02;

  // Bit positions in the ENEC and DISEC payload
  localparam int unsigned EventIntBit = 0;
  localparam int unsigned EventHjBit  = 3;

endpackage

/* verilog/bus_rx_flow.sv */
// Bus RX flow that samples SDA on SCL rising edges for bit and byte requests
`timescale 1ns/1ps

module bus_rx_flow
  import i3c_target_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  bus_state_t bus_i,
  input  bus_req_t   req_i,
  output logic       rx_done_o,
  output logic [7:0] rx_data_o
);

  logic       busy_q;
  logic [3:0] bits_left_q;
  logic [7:0] shift_q;
  logic       done_q;
  logic       sample;
  logic       abort;

  assign abort  = bus_i.start_det | bus_i.stop_det;
  assign sample = busy_q & bus_i.scl_posedge;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      bits_left_q <= '0;
      done_q      <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (abort) begin
        busy_q <= 1'b0;
      end else if (req_i.rx_req_byte || req_i.rx_req_bit) begin
        busy_q      <= 1'b1;
        bits_left_q <= req_i.rx_req_byte ? 4'd8 : 4'd1;
      end else if (sample) begin
        bits_left_q <= bits_left_q - 4'd1;
        if (bits_left_q == 4'd1) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // MSB first
  always_ff @(posedge clk_i) begin
    if (sample) begin
      shift_q <= {shift_q[6:0], bus_i.sda_value};
    end
  end

  assign rx_done_o = done_q;
  assign rx_data_o = shift_q;

endmodule

/* verilog/bus_tx_flow.sv */
// Bus TX flow that drives one requested bit on SDA for one SCL period
`timescale 1ns/1ps

module bus_tx_flow
  import i3c_target_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  bus_state_t bus_i,
  input  bus_req_t   req_i,
  output logic       tx_done_o,
  output logic       sda_o,
  output logic       sda_oe_o
);

  typedef enum logic [1:0] {
    tx_idle,
    tx_wait_neg,
    tx_drive
  } tx_state_e;

  tx_state_e state_q;
  logic      value_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= tx_idle;
      value_q   <= 1'b1;
      sda_o     <= 1'b1;
      sda_oe_o  <= 1'b0;
      tx_done_o <= 1'b0;
    end else begin
      tx_done_o <= 1'b0;
      if (bus_i.start_det || bus_i.stop_det) begin
        state_q  <= tx_idle;
        sda_o    <= 1'b1;
        sda_oe_o <= 1'b0;
      end else begin
        case (state_q)
          tx_idle: begin
            if (req_i.tx_req_bit) begin
              state_q <= tx_wait_neg;
              value_q <= req_i.tx_value;
            end
          end
          // SDA changes only while SCL is low
          tx_wait_neg: begin
            if (bus_i.scl_negedge) begin
              state_q  <= tx_drive;
              sda_o    <= value_q;
              sda_oe_o <= 1'b1;
            end
          end
          tx_drive: begin
            if (bus_i.scl_negedge) begin
              state_q   <= tx_idle;
              sda_o     <= 1'b1;
              sda_oe_o  <= 1'b0;
              tx_done_o <= 1'b1;
            end
          end
          default: state_q <= tx_idle;
        endcase
      end
    end
  end

endmodule

/* verilog/target_fsm.sv */
// Target FSM with address match, ACK, T-bit checked data bytes, RX byte port and CCC hand-off
`timescale 1ns/1ps

module target_fsm
  import i3c_target_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        enable_i,
  input  bus_state_t  bus_i,
  input  target_cfg_t cfg_i,
  output bus_req_t    req_o,
  input  bus_rsp_t    rsp_i,
  output logic        rx_valid_o,
  output logic [7:0]  rx_data_o,
  input  logic        rx_ready_i,
  output logic        parity_err_o,
  output logic        rx_overflow_o,
  output logic [7:0]  ccc_o,
  output logic        ccc_valid_o
);

  typedef enum logic [2:0] {
    st_idle,
    st_addr,
    st_ack,
    st_data,
    st_tbit,
    st_ccc
  } fsm_state_e;

  fsm_state_e state_q;
  logic       bcast_q;
  logic [7:0] byte_q;
  logic [6:0] own_addr;
  logic       own_addr_valid;
  logic       is_bcast;
  logic       addr_match;
  logic       tbit_done;
  logic       parity_ok;
  logic       deliver;
  logic       rx_slot_free;

  // Dynamic address replaces the static one once assigned
  assign own_addr       = cfg_i.dyn_addr_valid ? cfg_i.dyn_addr : cfg_i.sta_addr;
  assign own_addr_valid = cfg_i.dyn_addr_valid | cfg_i.sta_addr_valid;
  assign is_bcast       = rsp_i.rx_data[7:1] == BroadcastAddr;
  assign addr_match     = !rsp_i.rx_data[0] &&
                          (is_bcast || (own_addr_valid && rsp_i.rx_data[7:1] == own_addr));

  // Good when the nine bits have odd parity
  assign tbit_done    = (state_q == st_tbit) && rsp_i.rx_done;
  assign parity_ok    = ^{byte_q, rsp_i.rx_data[0]};
  assign deliver      = tbit_done && parity_ok && !bcast_q;
  assign rx_slot_free = !rx_valid_o || rx_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= st_idle;
      bcast_q      <= 1'b0;
      req_o        <= '0;
      ccc_valid_o  <= 1'b0;
      parity_err_o <= 1'b0;
    end else begin
      req_o        <= '0;
      ccc_valid_o  <= 1'b0;
      parity_err_o <= 1'b0;
      if (!enable_i || bus_i.stop_det) begin
        state_q <= st_idle;
      end else if (bus_i.start_det) begin
        state_q           <= st_addr;
        req_o.rx_req_byte <= 1'b1;
      end else begin
        case (state_q)
          st_addr: begin
            if (rsp_i.rx_done) begin
              if (addr_match) begin
                // ACK is a driven low bit
                state_q          <= st_ack;
                bcast_q          <= is_bcast;
                req_o.tx_req_bit <= 1'b1;
              end else begin
                state_q <= st_idle;
              end
            end
          end
          st_ack: begin
            if (rsp_i.tx_done) begin
              state_q           <= st_data;
              req_o.rx_req_byte <= 1'b1;
            end
          end
          st_data: begin
            if (rsp_i.rx_done) begin
              state_q          <= st_tbit;
              req_o.rx_req_bit <= 1'b1;
            end
          end
          st_tbit: begin
            if (tbit_done) begin
              if (!parity_ok) begin
                state_q      <= st_idle;
                parity_err_o <= 1'b1;
              end else if (bcast_q) begin
                state_q     <= st_ccc;
                ccc_valid_o <= 1'b1;
              end else begin
                state_q           <= st_data;
                req_o.rx_req_byte <= 1'b1;
              end
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == st_data && rsp_i.rx_done) begin
      byte_q <= rsp_i.rx_data;
    end
  end

  assign ccc_o = byte_q;

  // SCL cannot be stretched, so a byte without a free slot is lost
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_valid_o    <= 1'b0;
      rx_overflow_o <= 1'b0;
    end else begin
      if (rx_valid_o && rx_ready_i) begin
        rx_valid_o <= 1'b0;
      end
      if (bus_i.start_det) begin
        rx_overflow_o <= 1'b0;
      end
      if (deliver) begin
        if (rx_slot_free) begin
          rx_valid_o <= 1'b1;
        end else begin
          rx_overflow_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (deliver && rx_slot_free) begin
      rx_data_o <= byte_q;
    end
  end

endmodule

/* verilog/ccc_handler.sv */
// CCC handler for broadcast ENEC, DISEC, SETMWL and RSTACT, with the reset outputs
`timescale 1ns/1ps

module ccc_handler
  import i3c_target_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  bus_state_t  bus_i,
  input  logic [7:0]  ccc_i,
  input  logic        ccc_valid_i,
  output bus_req_t    req_o,
  input  bus_rsp_t    rsp_i,
  output logic        ccc_done_o,
  output ccc_events_t ccc_evt_o,
  output logic [15:0] mwl_o,
  output logic [7:0]  rst_action_o,
  output logic        peripheral_reset_o,
  input  logic        peripheral_reset_done_i,
  output logic        escalated_reset_o
);

  typedef enum logic [1:0] {
    cc_idle,
    cc_byte,
    cc_tbit,
    cc_end
  } ccc_state_e;

  ccc_state_e state_q;
  logic [7:0] code_q;
  logic       more_q;
  logic [7:0] byte_q;
  logic [7:0] msb_q;
  logic       has_payload;
  logic       parity_ok;
  logic       rstact_periph;
  logic       rstact_escalate;

  assign has_payload = ccc_i inside {CccEnec, CccDisec, CccSetmwl, CccRstact};
  assign parity_ok   = ^{byte_q, rsp_i.rx_data[0]};

  // Bus returns to the target FSM on STOP or repeated START
  assign ccc_done_o = (state_q != cc_idle) && (bus_i.start_det || bus_i.stop_det);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= cc_idle;
      code_q       <= '0;
      more_q       <= 1'b0;
      req_o        <= '0;
      ccc_evt_o    <= '0;
      mwl_o        <= '0;
      rst_action_o <= '0;
    end else begin
      req_o     <= '0;
      ccc_evt_o <= '0;
      if (bus_i.start_det || bus_i.stop_det) begin
        state_q <= cc_idle;
      end else begin
        case (state_q)
          cc_idle: begin
            if (ccc_valid_i) begin
              code_q <= ccc_i;
              more_q <= ccc_i == CccSetmwl;
              if (has_payload) begin
                state_q           <= cc_byte;
                req_o.rx_req_byte <= 1'b1;
              end else begin
                state_q <= cc_end;
              end
            end
          end
          cc_byte: begin
            if (rsp_i.rx_done) begin
              state_q          <= cc_tbit;
              req_o.rx_req_bit <= 1'b1;
            end
          end
          cc_tbit: begin
            if (rsp_i.rx_done) begin
              if (!parity_ok) begin
                state_q <= cc_end;
              end else if (more_q) begin
                more_q            <= 1'b0;
                state_q           <= cc_byte;
                req_o.rx_req_byte <= 1'b1;
              end else begin
                state_q <= cc_end;
                case (code_q)
                  CccEnec: begin
                    ccc_evt_o.enec_ibi <= byte_q[EventIntBit];
                    ccc_evt_o.enec_hj  <= byte_q[EventHjBit];
                  end
                  CccDisec: begin
                    ccc_evt_o.disec_ibi <= byte_q[EventIntBit];
                    ccc_evt_o.disec_hj  <= byte_q[EventHjBit];
                  end
                  CccSetmwl: begin
                    ccc_evt_o.set_mwl <= 1'b1;
                    mwl_o             <= {msb_q, byte_q};
                  end
                  CccRstact: begin
                    ccc_evt_o.rst_action_valid <= 1'b1;
                    rst_action_o               <= byte_q;
                  end
                  default: ;
                endcase
              end
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Previous byte moves up, giving the SETMWL MSB
  always_ff @(posedge clk_i) begin
    if (state_q == cc_byte && rsp_i.rx_done) begin
      byte_q <= rsp_i.rx_data;
      msb_q  <= byte_q;
    end
  end

  assign rstact_periph   = ccc_evt_o.rst_action_valid && rst_action_o == RstactPeriph;
  assign rstact_escalate = ccc_evt_o.rst_action_valid && rst_action_o == RstactEscalate;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      peripheral_reset_o <= 1'b0;
      escalated_reset_o  <= 1'b0;
    end else begin
      if (rstact_periph) begin
        peripheral_reset_o <= 1'b1;
      end
      if (peripheral_reset_done_i) begin
        peripheral_reset_o <= 1'b0;
      end
      // Held until the next hard reset
      if (rstact_escalate) begin
        escalated_reset_o <= 1'b1;
      end
    end
  end

endmodule

/* verilog/xfer_mux.sv */
// Bus owner selector routing requests and responses between target FSM and CCC handler
`timescale 1ns/1ps

module xfer_mux
  import i3c_target_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     ccc_valid_i,
  input  logic     ccc_done_i,
  input  bus_req_t fsm_req_i,
  input  bus_req_t ccc_req_i,
  output bus_req_t bus_req_o,
  input  bus_rsp_t bus_rsp_i,
  output bus_rsp_t fsm_rsp_o,
  output bus_rsp_t ccc_rsp_o
);

  xfer_sel_e sel_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q <= sel_fsm;
    end else if (sel_q == sel_fsm && ccc_valid_i) begin
      sel_q <= sel_ccc;
    end else if (sel_q == sel_ccc && ccc_done_i) begin
      sel_q <= sel_fsm;
    end
  end

  // Owner not selected sees an idle bus
  always_comb begin
    fsm_rsp_o = '0;
    ccc_rsp_o = '0;
    if (sel_q == sel_ccc) begin
      bus_req_o = ccc_req_i;
      ccc_rsp_o = bus_rsp_i;
    end else begin
      bus_req_o = fsm_req_i;
      fsm_rsp_o = bus_rsp_i;
    end
  end

endmodule

/* verilog/controller_standby_i3c.sv */
// Top level of the I3C standby target with FSM, CCC handler, transfer mux and bus flows
`timescale 1ns/1ps

module controller_standby_i3c
  import i3c_target_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        standby_en_i,
  input  bus_state_t  ctrl_bus_i,
  input  target_cfg_t target_cfg_i,
  output logic        sda_o,
  output logic        sda_oe_o,
  output logic        rx_valid_o,
  output logic [7:0]  rx_data_o,
  input  logic        rx_ready_i,
  output logic        parity_err_o,
  output logic        rx_overflow_o,
  output ccc_events_t ccc_evt_o,
  output logic [15:0] mwl_o,
  output logic [7:0]  rst_action_o,
  output logic        peripheral_reset_o,
  input  logic        peripheral_reset_done_i,
  output logic        escalated_reset_o
);

  bus_req_t   fsm_req;
  bus_req_t   ccc_req;
  bus_req_t   bus_req;
  bus_rsp_t   bus_rsp;
  bus_rsp_t   fsm_rsp;
  bus_rsp_t   ccc_rsp;
  logic       bus_rx_done;
  logic [7:0] bus_rx_data;
  logic       bus_tx_done;
  logic [7:0] ccc;
  logic       ccc_valid;
  logic       ccc_done;

  assign bus_rsp = '{rx_done: bus_rx_done, rx_data: bus_rx_data, tx_done: bus_tx_done};

  target_fsm i_target_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .enable_i      (standby_en_i),
    .bus_i         (ctrl_bus_i),
    .cfg_i         (target_cfg_i),
    .req_o         (fsm_req),
    .rsp_i         (fsm_rsp),
    .rx_valid_o    (rx_valid_o),
    .rx_data_o     (rx_data_o),
    .rx_ready_i    (rx_ready_i),
    .parity_err_o  (parity_err_o),
    .rx_overflow_o (rx_overflow_o),
    .ccc_o         (ccc),
    .ccc_valid_o   (ccc_valid)
  );

  ccc_handler i_ccc_handler (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .bus_i                   (ctrl_bus_i),
    .ccc_i                   (ccc),
    .ccc_valid_i             (ccc_valid),
    .req_o                   (ccc_req),
    .rsp_i                   (ccc_rsp),
    .ccc_done_o              (ccc_done),
    .ccc_evt_o               (ccc_evt_o),
    .mwl_o                   (mwl_o),
    .rst_action_o            (rst_action_o),
    .peripheral_reset_o      (peripheral_reset_o),
    .peripheral_reset_done_i (peripheral_reset_done_i),
    .escalated_reset_o       (escalated_reset_o)
  );

  xfer_mux i_xfer_mux (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ccc_valid_i (ccc_valid),
    .ccc_done_i  (ccc_done),
    .fsm_req_i   (fsm_req),
    .ccc_req_i   (ccc_req),
    .bus_req_o   (bus_req),
    .bus_rsp_i   (bus_rsp),
    .fsm_rsp_o   (fsm_rsp),
    .ccc_rsp_o   (ccc_rsp)
  );

  bus_rx_flow i_bus_rx_flow (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .bus_i     (ctrl_bus_i),
    .req_i     (bus_req),
    .rx_done_o (bus_rx_done),
    .rx_data_o (bus_rx_data)
  );

  bus_tx_flow i_bus_tx_flow (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .bus_i     (ctrl_bus_i),
    .req_i     (bus_req),
    .tx_done_o (bus_tx_done),
    .sda_o     (sda_o),
    .sda_oe_o  (sda_oe_o)
  );

endmodule

/* testbench/tb_controller_standby_i3c.sv */
// Directed testbench for the I3C standby target with bus tasks, monitors and six tests
`timescale 1ns/1ps

module tb_controller_standby_i3c
  import i3c_target_pkg::*;
();

  localparam int         BitGap         = 5;
  localparam int         TimeoutCycles  = 400;
  localparam int         WatchPeriph    = 0;
  localparam int         WatchEscalated = 1;
  localparam int         WatchOverflow  = 2;
  localparam logic [6:0] StaAddr        = 7'h3A;
  localparam logic [6:0] DynAddr        = 7'h22;
  localparam logic [6:0] ForeignAddr    = 7'h15;

  logic        clk;
  logic        rst_n;
  logic        standby_en;
  bus_state_t  ctrl_bus;
  target_cfg_t target_cfg;
  logic        sda;
  logic        sda_oe;
  logic        rx_valid;
  logic [7:0]  rx_data;
  logic        rx_ready;
  logic        parity_err;
  logic        rx_overflow;
  ccc_events_t ccc_evt;
  logic [15:0] mwl;
  logic [7:0]  rst_action;
  logic        periph_reset;
  logic        periph_done;
  logic        esc_reset;

  logic [7:0]  rx_q[$];
  int          parity_errs;
  ccc_events_t evt_acc;
  int          errors;
  int          passed;
  int          failed;
  integer      seed;

  controller_standby_i3c i_dut (
    .clk_i                   (clk),
    .rst_ni                  (rst_n),
    .standby_en_i            (standby_en),
    .ctrl_bus_i              (ctrl_bus),
    .target_cfg_i            (target_cfg),
    .sda_o                   (sda),
    .sda_oe_o                (sda_oe),
    .rx_valid_o              (rx_valid),
    .rx_data_o               (rx_data),
    .rx_ready_i              (rx_ready),
    .parity_err_o            (parity_err),
    .rx_overflow_o           (rx_overflow),
    .ccc_evt_o               (ccc_evt),
    .mwl_o                   (mwl),
    .rst_action_o            (rst_action),
    .peripheral_reset_o      (periph_reset),
    .peripheral_reset_done_i (periph_done),
    .escalated_reset_o       (esc_reset)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #1_000_000;
    $display("Simulation stopped by the watchdog before all tests ran");
    $display("Some tests failed");
    $finish;
  end

  // RX transfers, parity error pulses and CCC event pulses
  always @(negedge clk) begin
    if (rst_n) begin
      if (rx_valid && rx_ready) begin
        rx_q.push_back(rx_data);
      end
      if (parity_err) begin
        parity_errs++;
      end
      evt_acc = evt_acc | ccc_evt;
    end
  end

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check8(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got 8'h%02h expected 8'h%02h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check16(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got 16'h%04h expected 16'h%04h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_evt(input string name, input ccc_events_t got, input ccc_events_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got 6'b%06b expected 6'b%06b", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [7:0] next_byte();
    int rnd;
    rnd = $random(seed);
    return rnd[7:0];
  endfunction

  function automatic logic watched_level(input int which);
    case (which)
      WatchPeriph:    return periph_reset;
      WatchEscalated: return esc_reset;
      default:        return rx_overflow;
    endcase
  endfunction

  task automatic drive_bus(input logic start, input logic stop, input logic pos,
                           input logic neg, input logic level);
    @(posedge clk);
    ctrl_bus <= '{start_det: start, stop_det: stop, scl_posedge: pos,
                  scl_negedge: neg, sda_value: level};
  endtask

  task automatic hold_bus(input int cycles, input logic level);
    repeat (cycles) drive_bus(1'b0, 1'b0, 1'b0, 1'b0, level);
  endtask

  task automatic send_start();
    drive_bus(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
    hold_bus(4, 1'b1);
  endtask

  task automatic send_stop();
    drive_bus(1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
    hold_bus(8, 1'b1);
  endtask

  // SCL high phase then low phase of a few clocks each
  task automatic send_bit(input logic value);
    drive_bus(1'b0, 1'b0, 1'b1, 1'b0, value);
    hold_bus(BitGap, value);
    drive_bus(1'b0, 1'b0, 1'b0, 1'b1, value);
    hold_bus(BitGap, value);
  endtask

  task automatic send_addr(input logic [6:0] addr, input logic rnw, output logic acked);
    for (int i = 6; i >= 0; i--) begin
      send_bit(addr[i]);
    end
    send_bit(rnw);
    // SDA released by the controller in the ninth period
    drive_bus(1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
    @(negedge clk);
    acked = sda_oe && !sda;
    hold_bus(BitGap, 1'b1);
    drive_bus(1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
    hold_bus(BitGap, 1'b1);
  endtask

  task automatic send_byte_t(input logic [7:0] data, input logic corrupt);
    logic tbit;
    // Odd parity over the nine bits
    tbit = ~(^data) ^ corrupt;
    for (int i = 7; i >= 0; i--) begin
      send_bit(data[i]);
    end
    send_bit(tbit);
  endtask

  task automatic send_ccc(input logic [7:0] code, input int len, input logic [15:0] payload);
    logic acked;
    send_start();
    send_addr(BroadcastAddr, 1'b0, acked);
    check_bit("ACK on broadcast address", acked, 1'b1);
    send_byte_t(code, 1'b0);
    if (len == 2) begin
      send_byte_t(payload[15:8], 1'b0);
    end
    send_byte_t(payload[7:0], 1'b0);
    send_stop();
  endtask

  task automatic set_cfg(input logic dyn_valid);
    @(posedge clk);
    target_cfg <= '{sta_addr: StaAddr, sta_addr_valid: 1'b1,
                    dyn_addr: DynAddr, dyn_addr_valid: dyn_valid};
  endtask

  task automatic clear_monitors();
    @(posedge clk);
    rx_q.delete();
    parity_errs = 0;
    evt_acc     = '0;
  endtask

  task automatic wait_rx_count(input int count);
    int cycles;
    cycles = 0;
    while (rx_q.size() < count && cycles < TimeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    if (rx_q.size() < count) begin
      $display("ERROR at %0t: timed out waiting for %0d RX bytes, %0d arrived",
               $time, count, rx_q.size());
      errors++;
    end
  endtask

  task automatic wait_evt();
    int cycles;
    cycles = 0;
    while (evt_acc == '0 && cycles < TimeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    if (evt_acc == '0) begin
      $display("ERROR at %0t: timed out waiting for a CCC event pulse", $time);
      errors++;
    end
    @(negedge clk);
  endtask

  task automatic wait_level(input int which, input logic level, input string name);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (watched_level(which) !== level && cycles < TimeoutCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (watched_level(which) !== level) begin
      $display("ERROR at %0t: %s did not go to %b in time", $time, name, level);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("PASS %s", name);
      passed++;
    end else begin
      $display("FAIL %s with %0d errors", name, errors - errors_before);
      failed++;
    end
  endtask

  task automatic test_static_write();
    int         errors_before;
    logic       acked;
    logic [7:0] exp_q[$];
    logic [7:0] value;
    errors_before = errors;
    clear_monitors();
    send_start();
    send_addr(StaAddr, 1'b0, acked);
    check_bit("ACK on static address", acked, 1'b1);
    for (int i = 0; i < 4; i++) begin
      value = next_byte();
      exp_q.push_back(value);
      send_byte_t(value, 1'b0);
    end
    send_stop();
    wait_rx_count(exp_q.size());
    check8("RX byte count", 8'(rx_q.size()), 8'(exp_q.size()));
    for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
      check8("rx_data_o", rx_q[i], exp_q[i]);
    end
    check8("parity_err_o pulses", 8'(parity_errs), 8'd0);
    report_test("static address private write", errors_before);
  endtask

  task automatic test_address_match();
    int         errors_before;
    logic       acked;
    logic [7:0] value;
    errors_before = errors;
    clear_monitors();
    send_start();
    send_addr(ForeignAddr, 1'b0, acked);
    check_bit("ACK on foreign address", acked, 1'b0);
    send_byte_t(next_byte(), 1'b0);
    send_stop();
    set_cfg(1'b1);
    send_start();
    send_addr(StaAddr, 1'b0, acked);
    check_bit("ACK on static address with dynamic valid", acked, 1'b0);
    send_stop();
    hold_bus(20, 1'b1);
    check8("RX byte count", 8'(rx_q.size()), 8'd0);
    value = next_byte();
    send_start();
    send_addr(DynAddr, 1'b0, acked);
    check_bit("ACK on dynamic address", acked, 1'b1);
    send_byte_t(value, 1'b0);
    send_stop();
    wait_rx_count(1);
    check8("RX byte count", 8'(rx_q.size()), 8'd1);
    if (rx_q.size() > 0) begin
      check8("rx_data_o", rx_q[0], value);
    end
    set_cfg(1'b0);
    report_test("address match", errors_before);
  endtask

  task automatic test_parity_error();
    int         errors_before;
    logic       acked;
    logic [7:0] good;
    errors_before = errors;
    clear_monitors();
    good = next_byte();
    send_start();
    send_addr(StaAddr, 1'b0, acked);
    send_byte_t(good, 1'b0);
    send_byte_t(next_byte(), 1'b1);
    send_stop();
    wait_rx_count(1);
    hold_bus(20, 1'b1);
    check8("RX byte count", 8'(rx_q.size()), 8'd1);
    if (rx_q.size() > 0) begin
      check8("rx_data_o", rx_q[0], good);
    end
    check8("parity_err_o pulses", 8'(parity_errs), 8'd1);
    report_test("T-bit parity error", errors_before);
  endtask

  task automatic test_backpressure();
    int         errors_before;
    logic       acked;
    logic [7:0] first;
    errors_before = errors;
    clear_monitors();
    first = next_byte();
    rx_ready <= 1'b0;
    send_start();
    send_addr(StaAddr, 1'b0, acked);
    send_byte_t(first, 1'b0);
    send_byte_t(next_byte(), 1'b0);
    wait_level(WatchOverflow, 1'b1, "rx_overflow_o");
    check_bit("rx_valid_o", rx_valid, 1'b1);
    check8("rx_data_o", rx_data, first);
    send_stop();
    @(posedge clk);
    rx_ready <= 1'b1;
    wait_rx_count(1);
    hold_bus(20, 1'b1);
    check8("RX byte count", 8'(rx_q.size()), 8'd1);
    if (rx_q.size() > 0) begin
      check8("rx_data_o", rx_q[0], first);
    end
    @(negedge clk);
    check_bit("rx_overflow_o before START", rx_overflow, 1'b1);
    send_start();
    wait_level(WatchOverflow, 1'b0, "rx_overflow_o");
    send_stop();
    report_test("RX back-pressure and overflow", errors_before);
  endtask

  task automatic test_enec_disec();
    int          errors_before;
    logic        acked;
    logic [7:0]  value;
    ccc_events_t exp_evt;
    errors_before = errors;
    clear_monitors();
    send_ccc(CccEnec, 1, 16'h0009);
    wait_evt();
    exp_evt          = '0;
    exp_evt.enec_ibi = 1'b1;
    exp_evt.enec_hj  = 1'b1;
    check_evt("ccc_evt_o after ENEC", evt_acc, exp_evt);
    clear_monitors();
    send_ccc(CccDisec, 1, 16'h0001);
    wait_evt();
    exp_evt           = '0;
    exp_evt.disec_ibi = 1'b1;
    check_evt("ccc_evt_o after DISEC", evt_acc, exp_evt);
    // Private write after the CCC shows the bus is back with the FSM
    value = next_byte();
    send_start();
    send_addr(StaAddr, 1'b0, acked);
    check_bit("ACK after CCC", acked, 1'b1);
    send_byte_t(value, 1'b0);
    send_stop();
    wait_rx_count(1);
    if (rx_q.size() > 0) begin
      check8("rx_data_o", rx_q[0], value);
    end
    report_test("ENEC and DISEC", errors_before);
  endtask

  task automatic test_setmwl_rstact();
    int          errors_before;
    ccc_events_t exp_evt;
    errors_before = errors;
    clear_monitors();
    send_ccc(CccSetmwl, 2, 16'h1234);
    wait_evt();
    exp_evt         = '0;
    exp_evt.set_mwl = 1'b1;
    check_evt("ccc_evt_o after SETMWL", evt_acc, exp_evt);
    check16("mwl_o", mwl, 16'h1234);
    clear_monitors();
    send_ccc(CccRstact, 1, 16'h0001);
    wait_evt();
    exp_evt                  = '0;
    exp_evt.rst_action_valid = 1'b1;
    check_evt("ccc_evt_o after RSTACT", evt_acc, exp_evt);
    check8("rst_action_o", rst_action, 8'h01);
    wait_level(WatchPeriph, 1'b1, "peripheral_reset_o");
    // Reset stays up until the peripheral reports done
    hold_bus(10, 1'b1);
    @(negedge clk);
    check_bit("peripheral_reset_o before done", periph_reset, 1'b1);
    @(posedge clk);
    periph_done <= 1'b1;
    @(posedge clk);
    periph_done <= 1'b0;
    wait_level(WatchPeriph, 1'b0, "peripheral_reset_o");
    check_bit("escalated_reset_o", esc_reset, 1'b0);
    clear_monitors();
    send_ccc(CccRstact, 1, 16'h0002);
    wait_evt();
    exp_evt                  = '0;
    exp_evt.rst_action_valid = 1'b1;
    check_evt("ccc_evt_o after escalating RSTACT", evt_acc, exp_evt);
    check8("rst_action_o", rst_action, 8'h02);
    wait_level(WatchEscalated, 1'b1, "escalated_reset_o");
    hold_bus(30, 1'b1);
    @(negedge clk);
    check_bit("escalated_reset_o held", esc_reset, 1'b1);
    check_bit("peripheral_reset_o", periph_reset, 1'b0);
    report_test("SETMWL and RSTACT", errors_before);
  endtask

  initial begin
    seed        = 32'hcebe77b6;
    errors      = 0;
    passed      = 0;
    failed      = 0;
    parity_errs = 0;
    evt_acc     = '0;
    rst_n       <= 1'b0;
    standby_en  <= 1'b1;
    ctrl_bus    <= '0;
    target_cfg  <= '{sta_addr: StaAddr, sta_addr_valid: 1'b1,
                     dyn_addr: DynAddr, dyn_addr_valid: 1'b0};
    rx_ready    <= 1'b1;
    periph_done <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    hold_bus(4, 1'b1);
    test_static_write();
    test_address_match();
    test_parity_error();
    test_backpressure();
    test_enec_disec();
    test_setmwl_rstact();
    $display("Tests run: %0d passed, %0d failed, %0d check errors", passed, failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* flist.f */
verilog/i3c_target_pkg.sv
verilog/bus_rx_flow.sv
verilog/bus_tx_flow.sv
verilog/target_fsm.sv
verilog/ccc_handler.sv
verilog/xfer_mux.sv
verilog/controller_standby_i3c.sv
testbench/tb_controller_standby_i3c.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f flist.f \
  --top-module tb_controller_standby_i3c -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep "All tests passed" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
